//--- source/zx_pkg.sv
`default_nettype none

package zx_pkg;

	////////////////////////////////////////
	// widths that carry a meaning
	////////////////////////////////////////

	// z80 address and data bus
	typedef logic [15:0] zaddr_t;
	typedef logic [7:0] zdata_t;

	// window page, bit 7 set selects ROM
	typedef logic [7:0] page_t;

	// window index from address bits 15:14
	typedef logic [1:0] win_t;

	// paged memory address, page and 14-bit offset
	typedef logic [21:0] maddr_t;

	////////////////////////////////////////
	// port addresses
	////////////////////////////////////////

	// window page port, matched on the low byte only
	localparam zdata_t PORT_PAGE_LOW = 8'h77;

	// extended config port, full 16-bit match
	localparam zaddr_t PORT_EFF7 = 16'hEFF7;

	////////////////////////////////////////
	// fixed pentagon mapping
	////////////////////////////////////////

	// ram pages seen at 4000 and 8000 with the pager off
	localparam page_t PENT_WIN1_PAGE = 8'd5;
	localparam page_t PENT_WIN2_PAGE = 8'd2;

	// bus sequencer states
	typedef enum logic [1:0] {
		IDLE,
		IO_EVENT,
		MEM_EVENT,
		HOLD
	} bus_state_t;

endpackage

`default_nettype wire

//--- source/z80_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface z80_bus_if;
	import zx_pkg::*;

	// one-cycle bus events
	logic io_wr;
	logic io_rd;
	logic mem_req;

	// payload, valid while an event is high
	zaddr_t addr;
	zdata_t wdata;

	// sequencer side
	modport seq (
		output io_wr,
		output io_rd,
		output mem_req,
		output addr,
		output wdata
	);

	// port registers, pager and address map
	modport dp (
		input io_wr,
		input io_rd,
		input mem_req,
		input addr,
		input wdata
	);

endinterface

`default_nettype wire

//--- source/bus_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module bus_sequencer (
	input  logic           fclk,
	input  logic           reset,
	input  logic           iorq_n,
	input  logic           mreq_n,
	input  logic           rd_n,
	input  logic           wr_n,
	input  logic           m1_n,
	input  zx_pkg::zaddr_t a,
	input  zx_pkg::zdata_t d_in,
	z80_bus_if.seq         bus
);
	import zx_pkg::*;

	logic iorq_s;
	logic mreq_s;
	logic rd_s;
	logic wr_s;
	logic m1_s;
	zaddr_t a_s;
	zdata_t d_s;
	bus_state_t state;
	logic io_cycle;
	logic ack_cycle;
	logic mem_cycle;
	logic bus_free;

	////////////////////////////////////////
	// strobe sampling
	////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			iorq_s <= 1'b1;
			mreq_s <= 1'b1;
			rd_s <= 1'b1;
			wr_s <= 1'b1;
			m1_s <= 1'b1;
		end
		else
		begin
			iorq_s <= iorq_n;
			mreq_s <= mreq_n;
			rd_s <= rd_n;
			wr_s <= wr_n;
			m1_s <= m1_n;
		end
	end

	// address and data taken along with the strobes
	always_ff @(posedge fclk)
	begin
		a_s <= a;
		d_s <= d_in;
	end

	assign io_cycle = !iorq_s && (!rd_s || !wr_s);
	// iorq together with m1 is an interrupt acknowledge, not a port access
	assign ack_cycle = !iorq_s && !m1_s;
	assign mem_cycle = !mreq_s && (!rd_s || !wr_s);
	assign bus_free = iorq_s && mreq_s;

	////////////////////////////////////////
	// event state machine
	////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			state <= IDLE;
			bus.io_wr <= 1'b0;
			bus.io_rd <= 1'b0;
			bus.mem_req <= 1'b0;
		end
		else
		begin
			bus.io_wr <= 1'b0;
			bus.io_rd <= 1'b0;
			bus.mem_req <= 1'b0;
			case (state)
				IDLE:
				begin
					if (ack_cycle)
						state <= HOLD;
					else if (io_cycle)
					begin
						state <= IO_EVENT;
						bus.io_wr <= !wr_s;
						bus.io_rd <= wr_s;
					end
					else if (mem_cycle)
					begin
						state <= MEM_EVENT;
						bus.mem_req <= 1'b1;
					end
				end
				IO_EVENT, MEM_EVENT:
					state <= HOLD;
				// wait for the z80 to end its cycle
				HOLD:
				begin
					if (bus_free)
						state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// payload latched on the edge that raises the event
	always_ff @(posedge fclk)
	begin
		if (state == IDLE)
		begin
			bus.addr <= a_s;
			bus.wdata <= d_s;
		end
	end

	event_exclusive: assert property (
		@(posedge fclk) disable iff (reset)
		$onehot0({bus.io_wr, bus.io_rd, bus.mem_req})
	) else $error("bus_sequencer: overlapping bus events");

endmodule

`default_nettype wire

//--- source/port_regs.sv
`timescale 1ns/10ps
`default_nettype none

module port_regs (
	input  logic           fclk,
	input  logic           reset,
	z80_bus_if.dp          bus,
	output zx_pkg::zdata_t p7ffd,
	output zx_pkg::zdata_t eff7,
	output logic [2:0]     border
);
	import zx_pkg::*;

	logic hit_7ffd;
	logic hit_eff7;
	logic hit_border;

	////////////////////////////////////////
	// port decode
	////////////////////////////////////////

	// partial decode as on the original machine
	assign hit_7ffd = !bus.addr[15] && !bus.addr[1] && bus.addr[0];
	assign hit_eff7 = (bus.addr == PORT_EFF7);
	// any even port is the ULA
	assign hit_border = !bus.addr[0];

	////////////////////////////////////////
	// registers
	////////////////////////////////////////

	// paging mode, rom select and top ram page
	always_ff @(posedge fclk)
	begin
		if (reset)
			p7ffd <= '0;
		else if (bus.io_wr && hit_7ffd)
			p7ffd <= bus.wdata;
	end

	// bit 3 turns the window pager on
	always_ff @(posedge fclk)
	begin
		if (reset)
			eff7 <= '0;
		else if (bus.io_wr && hit_eff7)
			eff7 <= bus.wdata;
	end

	// border colour
	always_ff @(posedge fclk)
	begin
		if (reset)
			border <= 3'd0;
		else if (bus.io_wr && hit_border)
			border <= bus.wdata[2:0];
	end

endmodule

`default_nettype wire

//--- source/window_pager.sv
`timescale 1ns/10ps
`default_nettype none

module window_pager (
	input  logic           fclk,
	input  logic           reset,
	z80_bus_if.dp          bus,
	output zx_pkg::page_t  pages [4],
	output zx_pkg::zdata_t rd_data,
	output logic           rd_hit
);
	import zx_pkg::*;

	win_t win;
	logic page_port;

	// window chosen by the high address bits of the port access
	assign win = bus.addr[15:14];
	assign page_port = (bus.addr[7:0] == PORT_PAGE_LOW);

	////////////////////////////////////////
	// page registers
	////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 4; i++)
				pages[i] <= '0;
		end
		else if (bus.io_wr && page_port)
			pages[win] <= page_t'(bus.wdata);
	end

	////////////////////////////////////////
	// readback
	////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
			rd_data <= '0;
		else if (bus.io_rd && page_port)
			rd_data <= zdata_t'(pages[win]);
	end

	// data is driven from the read event until the
	// next bus event, which cannot come before the
	// z80 has released iorq and rd
	always_ff @(posedge fclk)
	begin
		if (reset)
			rd_hit <= 1'b0;
		else if (bus.io_rd)
			rd_hit <= page_port;
		else if (bus.io_wr || bus.mem_req)
			rd_hit <= 1'b0;
	end

endmodule

`default_nettype wire

//--- source/address_map.sv
`timescale 1ns/10ps
`default_nettype none

module address_map (
	input  logic           fclk,
	input  logic           reset,
	z80_bus_if.dp          bus,
	input  zx_pkg::page_t  pages [4],
	input  zx_pkg::zdata_t p7ffd,
	input  zx_pkg::zdata_t eff7,
	output zx_pkg::maddr_t mem_addr,
	output logic           mem_rom
);
	import zx_pkg::*;

	localparam int PAGER_ON_BIT = 3;

	win_t win;
	logic pager_on;
	page_t sel_page;
	logic sel_rom;

	assign win = bus.addr[15:14];
	assign pager_on = eff7[PAGER_ON_BIT];

	////////////////////////////////////////
	// page select
	////////////////////////////////////////

	always_comb
	begin
		sel_page = pages[win];
		sel_rom = sel_page[7];
		if (!pager_on)
		begin
			sel_rom = 1'b0;
			case (win)
				2'd0:
				begin
					// 128k or 48k basic rom
					sel_page = {7'd0, p7ffd[4]};
					sel_rom = 1'b1;
				end
				2'd1:
					sel_page = PENT_WIN1_PAGE;
				2'd2:
					sel_page = PENT_WIN2_PAGE;
				default:
					sel_page = {5'd0, p7ffd[2:0]};
			endcase
		end
	end

	// translated address held until the next memory cycle
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			mem_addr <= '0;
			mem_rom <= 1'b0;
		end
		else if (bus.mem_req)
		begin
			mem_addr <= {sel_page, bus.addr[13:0]};
			mem_rom <= sel_rom;
		end
	end

endmodule

`default_nettype wire

//--- source/frame_int.sv
`timescale 1ns/10ps
`default_nettype none

module frame_int #(
	parameter int FRAME_LEN = 71680,
	parameter int INT_LEN = 32
) (
	input  logic fclk,
	input  logic reset,
	input  logic iorq_n,
	input  logic m1_n,
	output logic int_n
);

	localparam int FRAME_W = $clog2(FRAME_LEN);
	localparam int INT_W = $clog2(INT_LEN + 1);

	logic [FRAME_W-1:0] frame_cnt;
	logic [INT_W-1:0] int_cnt;
	logic int_ack;

	// free running frame position
	always_ff @(posedge fclk)
	begin
		if (reset)
			frame_cnt <= '0;
		else if (frame_cnt == FRAME_W'(FRAME_LEN - 1))
			frame_cnt <= '0;
		else
			frame_cnt <= frame_cnt + 1'b1;
	end

	assign int_ack = !iorq_n && !m1_n;

	////////////////////////////////////////
	// interrupt pulse
	////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			int_n <= 1'b1;
			int_cnt <= '0;
		end
		else if (frame_cnt == '0)
		begin
			int_n <= 1'b0;
			int_cnt <= '0;
		end
		else if (!int_n)
		begin
			// acknowledged or timed out
			if (int_ack || int_cnt == INT_W'(INT_LEN - 1))
				int_n <= 1'b1;
			else
				int_cnt <= int_cnt + 1'b1;
		end
	end

	int_pulse_bounded: assert property (
		@(posedge fclk) disable iff (reset)
		$fell(int_n) |-> ##[1:INT_LEN] int_n
	) else $error("frame_int: int_n low for more than %0d cycles", INT_LEN);

endmodule

`default_nettype wire

//--- source/zx_paging_top.sv
`timescale 1ns/10ps
`default_nettype none

module zx_paging_top #(
	parameter int FRAME_LEN = 71680,
	parameter int INT_LEN = 32
) (
	input  logic           fclk,
	input  logic           reset,
	// z80 strobes
	input  logic           iorq_n,
	input  logic           mreq_n,
	input  logic           rd_n,
	input  logic           wr_n,
	input  logic           m1_n,
	input  zx_pkg::zaddr_t a,
	// split data bus
	input  zx_pkg::zdata_t d_in,
	output zx_pkg::zdata_t d_out,
	output logic           d_oe,
	// paged memory side
	output zx_pkg::maddr_t mem_addr,
	output logic           mem_rom,
	output logic [2:0]     border,
	output logic           int_n
);
	import zx_pkg::*;

	zdata_t p7ffd;
	zdata_t eff7;
	page_t window_pager_page [4];

	z80_bus_if bus_if ();

	bus_sequencer bus_sequencer_inst (
		.fclk   (fclk),
		.reset  (reset),
		.iorq_n (iorq_n),
		.mreq_n (mreq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.a      (a),
		.d_in   (d_in),
		.bus    (bus_if.seq)
	);

	port_regs port_regs_inst (
		.fclk   (fclk),
		.reset  (reset),
		.bus    (bus_if.dp),
		.p7ffd  (p7ffd),
		.eff7   (eff7),
		.border (border)
	);

	////////////////////////////////////////
	// memory paging
	////////////////////////////////////////

	window_pager window_pager_inst (
		.fclk    (fclk),
		.reset   (reset),
		.bus     (bus_if.dp),
		.pages   (window_pager_page),
		.rd_data (d_out),
		.rd_hit  (d_oe)
	);

	address_map address_map_inst (
		.fclk     (fclk),
		.reset    (reset),
		.bus      (bus_if.dp),
		.pages    (window_pager_page),
		.p7ffd    (p7ffd),
		.eff7     (eff7),
		.mem_addr (mem_addr),
		.mem_rom  (mem_rom)
	);

	frame_int #(
		.FRAME_LEN (FRAME_LEN),
		.INT_LEN   (INT_LEN)
	) frame_int_inst (
		.fclk   (fclk),
		.reset  (reset),
		.iorq_n (iorq_n),
		.m1_n   (m1_n),
		.int_n  (int_n)
	);

endmodule

`default_nettype wire

//--- bench/tb_zx_paging.sv
`timescale 1ns/10ps
`default_nettype none

module tb_zx_paging;
	import zx_pkg::*;

	localparam int FRAME_LEN = 200;
	localparam int INT_LEN = 8;
	localparam int FRAME_MARGIN = 16;

	logic fclk;
	logic reset;
	logic iorq_n;
	logic mreq_n;
	logic rd_n;
	logic wr_n;
	logic m1_n;
	zaddr_t a;
	zdata_t d_in;
	zdata_t d_out;
	logic d_oe;
	maddr_t mem_addr;
	logic mem_rom;
	logic [2:0] border;
	logic int_n;

	int checks;
	int mismatches;
	int failures;
	int ops;
	logic [31:0] rng;
	logic [2:0] exp_border;

	zx_paging_top #(
		.FRAME_LEN (FRAME_LEN),
		.INT_LEN   (INT_LEN)
	) zx_paging_top_inst (
		.fclk     (fclk),
		.reset    (reset),
		.iorq_n   (iorq_n),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.a        (a),
		.d_in     (d_in),
		.d_out    (d_out),
		.d_oe     (d_oe),
		.mem_addr (mem_addr),
		.mem_rom  (mem_rom),
		.border   (border),
		.int_n    (int_n)
	);

	initial
	begin
		fclk = 1'b0;
		forever #4 fclk = ~fclk;
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		mismatches++;
	endtask

	task automatic report_failure(input string msg);
		$display("error at %0t: %s", $time, msg);
		failures++;
	endtask

	// inputs change only on the falling edge
	task automatic next_cycle();
		@(posedge fclk);
		@(negedge fclk);
	endtask

	task automatic idle_gap();
		int gap;
		rng = xorshift32(rng);
		gap = int'(rng[1:0]);
		for (int i = 0; i < gap; i++)
			next_cycle();
	endtask

	// end of a z80 cycle with strobes high for at least one edge
	task automatic release_bus();
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		m1_n = 1'b1;
		next_cycle();
		idle_gap();
	endtask

	////////////////////////////////////////
	// z80 cycles
	////////////////////////////////////////

	// sample, event, register update
	task automatic io_write(input zaddr_t addr, input zdata_t data);
		a = addr;
		d_in = data;
		iorq_n = 1'b0;
		wr_n = 1'b0;
		repeat (3) next_cycle();
		// ula answers on every even port
		if (!addr[0])
			exp_border = data[2:0];
		checks++;
		if (border !== exp_border)
			report_mismatch("border", border, exp_border);
		release_bus();
	endtask

	task automatic io_read(input zaddr_t addr, input zdata_t expected);
		logic page_port;
		page_port = (addr[7:0] == 8'h77);
		a = addr;
		iorq_n = 1'b0;
		rd_n = 1'b0;
		repeat (3) next_cycle();
		checks++;
		if (d_oe !== page_port)
			report_mismatch("d_oe", d_oe, page_port);
		if (page_port)
		begin
			checks++;
			if (d_out !== expected)
				report_mismatch("d_out", d_out, expected);
		end
		// still driven while the read strobes stay low
		next_cycle();
		checks++;
		if (d_oe !== page_port)
			report_mismatch("d_oe", d_oe, page_port);
		release_bus();
	endtask

	task automatic mem_read(input zaddr_t addr, input maddr_t exp_addr, input logic exp_rom);
		a = addr;
		mreq_n = 1'b0;
		rd_n = 1'b0;
		repeat (3) next_cycle();
		checks++;
		if (mem_addr !== exp_addr)
			report_mismatch("mem_addr", mem_addr, exp_addr);
		checks++;
		if (mem_rom !== exp_rom)
			report_mismatch("mem_rom", mem_rom, exp_rom);
		release_bus();
	endtask

	////////////////////////////////////////
	// golden vector replay
	////////////////////////////////////////

	task automatic replay_golden();
		int fd;
		int code;
		int ch;
		logic [7:0] op;
		logic [31:0] addr;
		logic [31:0] value;
		logic [31:0] rom;
		logic done;
		fd = $fopen("bench/zx_paging_golden.txt", "r");
		if (fd == 0)
		begin
			report_failure("cannot open bench/zx_paging_golden.txt");
			return;
		end
		done = 1'b0;
		while (!done)
		begin
			code = $fscanf(fd, " %c", op);
			if (code != 1)
				done = 1'b1;
			else if (op == "#")
			begin
				// rest of a comment line
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1)
					ch = $fgetc(fd);
			end
			else if (op == "W" || op == "R")
			begin
				code = $fscanf(fd, "%h %h", addr, value);
				if (code != 2)
				begin
					report_failure("golden file has a W or R line without address and value");
					done = 1'b1;
				end
				else
				begin
					ops++;
					if (op == "W")
						io_write(addr[15:0], value[7:0]);
					else
						io_read(addr[15:0], value[7:0]);
				end
			end
			else if (op == "M")
			begin
				code = $fscanf(fd, "%h %h %h", addr, value, rom);
				if (code != 3)
				begin
					report_failure("golden file has an M line without three fields");
					done = 1'b1;
				end
				else
				begin
					ops++;
					mem_read(addr[15:0], value[21:0], rom[0]);
				end
			end
			else
			begin
				report_failure("golden file has an unknown operation");
				done = 1'b1;
			end
		end
		$fclose(fd);
		if (ops == 0)
			report_failure("no operations were read from the golden file");
	endtask

	////////////////////////////////////////
	// frame interrupt
	////////////////////////////////////////

	task automatic check_interrupt();
		int cycles;
		logic [2:0] border_before;
		// let a pulse in progress finish
		cycles = 0;
		while (!int_n && cycles < INT_LEN + 4)
		begin
			next_cycle();
			cycles++;
		end
		if (!int_n)
			report_failure("int_n stuck low before the frame test");
		cycles = 0;
		while (int_n && cycles < FRAME_LEN + FRAME_MARGIN)
		begin
			next_cycle();
			cycles++;
		end
		if (int_n)
		begin
			report_failure("int_n did not go low within one frame");
			return;
		end
		// unacknowledged pulse length
		cycles = 0;
		while (!int_n && cycles < INT_LEN + 4)
		begin
			next_cycle();
			cycles++;
		end
		checks++;
		if (!int_n)
			report_failure("int_n did not return high without an acknowledge");
		else if (cycles > INT_LEN)
			report_failure("int_n stayed low longer than the pulse length");
		cycles = 0;
		while (int_n && cycles < FRAME_LEN + FRAME_MARGIN)
		begin
			next_cycle();
			cycles++;
		end
		if (int_n)
		begin
			report_failure("int_n did not go low in the second frame");
			return;
		end
		border_before = border;
		// acknowledge cycle on an even port with a write strobe and data on the bus
		a = 16'h00fe;
		d_in = 8'h07;
		iorq_n = 1'b0;
		m1_n = 1'b0;
		wr_n = 1'b0;
		cycles = 0;
		while (!int_n && cycles < 2)
		begin
			next_cycle();
			cycles++;
		end
		checks++;
		if (!int_n)
			report_failure("int_n not released within 2 cycles of the acknowledge");
		while (cycles < 3)
		begin
			next_cycle();
			cycles++;
		end
		release_bus();
		checks++;
		if (border !== border_before)
			report_mismatch("border", border, border_before);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		reset = 1'b1;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		m1_n = 1'b1;
		a = '0;
		d_in = '0;
		checks = 0;
		mismatches = 0;
		failures = 0;
		ops = 0;
		rng = 32'h21f9;
		exp_border = 3'd0;
		repeat (2) @(posedge fclk);
		@(negedge fclk);
		reset = 1'b0;

		// state right after reset
		checks++;
		if (d_oe !== 1'b0)
			report_mismatch("d_oe", d_oe, 1'b0);
		checks++;
		if (int_n !== 1'b1)
			report_mismatch("int_n", int_n, 1'b1);
		checks++;
		if (mem_addr !== '0)
			report_mismatch("mem_addr", mem_addr, 0);
		checks++;
		if (border !== 3'd0)
			report_mismatch("border", border, 0);

		replay_golden();
		check_interrupt();

		$display("operations %0d, checks %0d, mismatches %0d, other errors %0d",
			ops, checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/zx_paging_golden.txt
# op addr value [rom], all hex; W = io write, R = io read expecting value on d_out
# M = memory read expecting mem_addr and mem_rom; R of a port other than xx77 expects d_oe low
# pentagon mapping after reset
R 00fe 00
R 7ffd 00
M 0123 000123 1
M 4567 014567 0
M 89ab 0089ab 0
M cdef 000def 0
# 7ffd selects rom 1 and ram page 3
W 7ffd 13
M 0010 004010 1
M c100 00c100 0
# addresses that fail the 7ffd decode
W fffd 07
W 7fff 07
M c200 00c200 0
M 0020 004020 1
# window page registers and readback
W 0077 81
W 4077 0a
W 8077 3c
W c077 97
R 0077 81
R 4077 0a
R 8077 3c
R c077 97
# pager on through eff7 bit 3
W eff7 08
M 0155 204155 1
M 7fff 02bfff 0
M 8000 0f0000 0
M fedc 25fedc 1
# border on even ports
W 00fe 05
W 12fc 0e
M 4000 028000 0

//--- filelist.f
source/zx_pkg.sv
source/z80_bus_if.sv
source/bus_sequencer.sv
source/port_regs.sv
source/window_pager.sv
source/address_map.sv
source/frame_int.sv
source/zx_paging_top.sv
bench/tb_zx_paging.sv
